// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_sdram
FLIST     = flist.f
OBJ_DIR   = obj_dir
SIM       = $(OBJ_DIR)/V$(TOP)
LOG       = sim.log
SRCS      = $(shell grep -v '^+' $(FLIST)) $(wildcard *.svh)

.PHONY: all run clean

all: run

$(SIM): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	grep -q "^=== PASS ===$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== flist.f ====
+incdir+.
sdram_pkg.sv
sdram_mode_regs.sv
sdram_ctrl.sv
sdram.sv
sdram_subsys_top.sv
sdram_sva.sv
tb_sdram.sv

// ==== sdram.sv ====
`include "sdram_macros.svh"

module sdram (
    input  logic        clk,
    input  logic        cke,
    input  logic        cs,
    input  logic        ras,
    input  logic        cas,
    input  logic        we,
    input  logic [12:0] a,
    input  logic [1:0]  ba,
    input  logic [1:0]  dqm,
    inout  wire  [15:0] dq
);
    import sdram_pkg::*;

    localparam int ROW_W = `SDRAM_ROW_BITS;
    localparam int COL_W = `SDRAM_COL_BITS;
    localparam int BANKS = 4;

    // Reduced array, banks x rows x cols of 16 bits
    logic [15:0] mem [BANKS][1 << ROW_W][1 << COL_W];

    // Per-bank open row
    logic             open_bank [BANKS];
    logic [ROW_W-1:0] open_row  [BANKS];

    // Per-bank burst engines
    logic [3:0]       rd_left [BANKS];
    logic [1:0]       rd_dly  [BANKS];
    logic [COL_W-1:0] rd_col  [BANKS];
    logic [3:0]       wr_left [BANKS];
    logic [COL_W-1:0] wr_col  [BANKS];

    // Mode register
    logic [2:0]  bl_code;
    logic [2:0]  cl;
    logic [3:0]  burst_len;
    sdram_cmd_e  cmd;

    logic [15:0] dq_out;
    logic        dq_en;

    assign dq = dq_en ? dq_out : 16'bz;
    assign cmd = sdram_cmd_e'({cs, ras, cas, we});
    // Reserved codes behave as single beat
    assign burst_len = (bl_code <= 3'd3) ? (4'd1 << bl_code[1:0]) : 4'd1;

    initial begin
        dq_en = 1'b0;
        for (int b = 0; b < BANKS; b++) begin
            open_bank[b] = 1'b0;
            rd_left[b]   = '0;
            wr_left[b]   = '0;
        end
    end

    // Masked write of the current dq into one word
    task automatic put_word(input logic [1:0] b, input logic [ROW_W-1:0] r,
                            input logic [COL_W-1:0] c);
        if (!dqm[0]) mem[b][r][c][7:0]  <= dq[7:0];
        if (!dqm[1]) mem[b][r][c][15:8] <= dq[15:8];
    endtask

    always @(posedge clk) begin
        if (cke) begin
            // Released unless some bank has a beat due
            dq_en <= 1'b0;
            for (int b = 0; b < BANKS; b++) begin
                // Write beats after the WRITE edge
                if (wr_left[b] != 4'd0) begin
                    put_word(2'(b), open_row[b], wr_col[b]);
                    wr_col[b]  <= wr_col[b] + 1'b1;
                    wr_left[b] <= wr_left[b] - 1'b1;
                end
                // Read beats once the CAS wait has run out
                if (rd_left[b] != 4'd0) begin
                    if (rd_dly[b] != 2'd0) begin
                        rd_dly[b] <= rd_dly[b] - 1'b1;
                    end else begin
                        dq_out     <= mem[b][open_row[b]][rd_col[b]];
                        dq_en      <= 1'b1;
                        rd_col[b]  <= rd_col[b] + 1'b1;
                        rd_left[b] <= rd_left[b] - 1'b1;
                    end
                end
            end
            case (cmd)
                CMD_LOAD_MODE: begin
                    bl_code <= a[2:0];
                    cl      <= a[6:4];
                end
                CMD_ACTIVE: begin
                    open_bank[ba] <= 1'b1;
                    open_row[ba]  <= a[ROW_W-1:0];
                end
                CMD_PRECHARGE: begin
                    // a10 high closes all banks
                    for (int b = 0; b < BANKS; b++) begin
                        if (a[10] || ba == 2'(b)) open_bank[b] <= 1'b0;
                    end
                end
                CMD_READ: begin
                    if (open_bank[ba]) begin
                        // First beat leaves CL-1 edges after READ
                        rd_dly[ba]  <= 2'(cl - 3'd2);
                        rd_left[ba] <= burst_len;
                        rd_col[ba]  <= a[COL_W-1:0];
                    end
                end
                CMD_WRITE: begin
                    if (open_bank[ba]) begin
                        // Beat 0 lands with the command
                        put_word(ba, open_row[ba], a[COL_W-1:0]);
                        wr_left[ba] <= burst_len - 4'd1;
                        wr_col[ba]  <= a[COL_W-1:0] + 1'b1;
                    end
                end
                // NOP, INHIBIT and REFRESH do nothing here
                default: ;
            endcase
        end
    end

endmodule

// ==== sdram_ctrl.sv ====
`include "sdram_macros.svh"

module sdram_ctrl (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   req,
    input  sdram_pkg::host_req_t   req_info,
    input  logic [15:0]            wdata,
    input  sdram_pkg::mode_cfg_t   cfg,
    input  logic                   mode_pending,
    output logic                   ready,
    output logic                   wdata_take,
    output logic                   rdata_valid,
    output logic                   done,
    output logic                   mode_loaded,
    output logic [15:0]            rdata,
    output sdram_pkg::sdram_pins_t pins,
    inout  wire  [15:0]            dq
);
    import sdram_pkg::*;

    localparam int INIT_W = $clog2(`SDRAM_INIT_CYCLES + 1);

    ctrl_state_e       state;
    logic [INIT_W-1:0] init_cnt;
    logic [2:0]        rcd_cnt;
    logic [2:0]        beat_cnt;
    host_req_t         cur_req;
    mode_cfg_t         act_cfg;
    sdram_cmd_e        cmd;
    logic [3:0]        bl_beats;
    logic              last_beat;
    logic [2:0]        rd_pipe;
    logic              cl3;
    logic              rd_tap;
    logic              rd_busy;

    // Burst length of the mode the device actually holds
    assign bl_beats  = 4'd1 << act_cfg.bl_code[1:0];
    assign last_beat = ({1'b0, beat_cnt} == bl_beats - 4'd1);

    // Read return tap sits CL stages down the pipe
    assign cl3     = (act_cfg.cas_latency == 3'd3);
    assign rd_tap  = cl3 ? rd_pipe[2] : rd_pipe[1];
    // Beats still in flight behind the tap
    assign rd_busy = cl3 ? |rd_pipe[1:0] : rd_pipe[0];

    assign ready       = (state == IDLE) && !mode_pending;
    assign wdata_take  = (state == WR);
    assign mode_loaded = (state == LOAD);

    // Controller owns dq only while write beats are on the bus
    assign dq = (state == WR) ? wdata : 16'bz;

    // Command decode from state
    always_comb begin
        cmd      = CMD_NOP;
        pins.a   = '0;
        pins.ba  = '0;
        pins.dqm = '0;
        case (state)
            INIT: begin
                // Last init cycle closes every bank
                if (init_cnt == INIT_W'(`SDRAM_INIT_CYCLES)) begin
                    cmd        = CMD_PRECHARGE;
                    pins.a[10] = 1'b1;
                end
            end
            LOAD: begin
                cmd    = CMD_LOAD_MODE;
                // Sequential burst, burst write, standard operation
                pins.a = {6'b0, cfg.cas_latency, 1'b0, cfg.bl_code};
            end
            ACT: begin
                cmd     = CMD_ACTIVE;
                pins.ba = cur_req.bank;
                pins.a  = 13'(cur_req.row);
            end
            RD: begin
                if (beat_cnt == 3'd0) begin
                    cmd     = CMD_READ;
                    pins.ba = cur_req.bank;
                    pins.a  = 13'(cur_req.col);
                end
            end
            WR: begin
                if (beat_cnt == 3'd0) begin
                    cmd     = CMD_WRITE;
                    pins.ba = cur_req.bank;
                    pins.a  = 13'(cur_req.col);
                end
                // Mask held for every beat of the burst
                pins.dqm = ~cur_req.be;
            end
            PRE: begin
                // Closed page, single bank with a10 low
                cmd     = CMD_PRECHARGE;
                pins.ba = cur_req.bank;
            end
            default: ;
        endcase
        {pins.cs_n, pins.ras_n, pins.cas_n, pins.we_n} = cmd;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state       <= INIT;
            init_cnt    <= '0;
            rcd_cnt     <= '0;
            beat_cnt    <= '0;
            act_cfg     <= '{cas_latency: 3'(`SDRAM_DEF_CL), bl_code: 3'(`SDRAM_DEF_BL_CODE)};
            rd_pipe     <= '0;
            rdata_valid <= 1'b0;
            done        <= 1'b0;
        end else begin
            // One mark per read beat slot
            rd_pipe     <= {rd_pipe[1:0], state == RD};
            rdata_valid <= rd_tap;
            done        <= (state == LOAD) || (state == PRE);
            case (state)
                INIT: begin
                    if (init_cnt == INIT_W'(`SDRAM_INIT_CYCLES)) begin
                        state <= LOAD;
                    end else begin
                        init_cnt <= init_cnt + 1'b1;
                    end
                end
                IDLE: begin
                    // Mode loads take priority over new accesses
                    if (mode_pending) begin
                        state <= LOAD;
                    end else if (req) begin
                        state <= ACT;
                    end
                end
                LOAD: begin
                    act_cfg <= cfg;
                    state   <= IDLE;
                end
                ACT: begin
                    rcd_cnt <= 3'(`SDRAM_TRCD - 2);
                    state   <= WAIT_RCD;
                end
                WAIT_RCD: begin
                    if (rcd_cnt == 3'd0) begin
                        beat_cnt <= '0;
                        state    <= cur_req.write ? WR : RD;
                    end else begin
                        rcd_cnt <= rcd_cnt - 1'b1;
                    end
                end
                RD: begin
                    if (last_beat) begin
                        state <= RD_WAIT;
                    end else begin
                        beat_cnt <= beat_cnt + 1'b1;
                    end
                end
                RD_WAIT: begin
                    // Last beat is captured on this edge
                    if (!rd_busy) begin
                        state <= PRE;
                    end
                end
                WR: begin
                    if (last_beat) begin
                        state <= PRE;
                    end else begin
                        beat_cnt <= beat_cnt + 1'b1;
                    end
                end
                PRE: begin
                    state <= IDLE;
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Request capture and read data register
    always_ff @(posedge clk) begin
        if (ready && req) begin
            cur_req <= req_info;
        end
        if (rd_tap) begin
            rdata <= dq;
        end
    end

endmodule

// ==== sdram_macros.svh ====
`ifndef SDRAM_MACROS_SVH
`define SDRAM_MACROS_SVH

// Reduced array geometry for simulation
// Bank address stays at the full 2 bits
`define SDRAM_ROW_BITS 4
`define SDRAM_COL_BITS 5

// ACTIVE to READ or WRITE, in clocks
`define SDRAM_TRCD 2

// Idle clocks after reset before the first PRECHARGE ALL
`define SDRAM_INIT_CYCLES 10

// Mode in force after reset
// CL 2, burst code 2 gives 4 beats
`define SDRAM_DEF_CL 2
`define SDRAM_DEF_BL_CODE 2

`endif

// ==== sdram_mode_regs.sv ====
`include "sdram_macros.svh"

module sdram_mode_regs (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  cfg_wr,
    input  sdram_pkg::mode_cfg_t  cfg_in,
    input  logic                  mode_loaded,
    output sdram_pkg::mode_cfg_t  cfg,
    output logic                  mode_pending
);
    import sdram_pkg::*;

    mode_cfg_t cfg_clean;

    // Clamp host values to what the controller supports
    always_comb begin
        cfg_clean = cfg_in;
        // Only CL 2 and 3 are legal
        if (cfg_in.cas_latency != 3'd2 && cfg_in.cas_latency != 3'd3) begin
            cfg_clean.cas_latency = 3'd2;
        end
        // Reserved burst codes fall back to a single beat
        if (cfg_in.bl_code > 3'd3) begin
            cfg_clean.bl_code = 3'd0;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cfg.cas_latency <= 3'(`SDRAM_DEF_CL);
            cfg.bl_code     <= 3'(`SDRAM_DEF_BL_CODE);
            // Pending out of reset so the init sequence loads the defaults
            mode_pending    <= 1'b1;
        end else if (cfg_wr) begin
            cfg          <= cfg_clean;
            // A write in the load cycle wins and forces another load
            mode_pending <= 1'b1;
        end else if (mode_loaded) begin
            mode_pending <= 1'b0;
        end
    end

endmodule

// ==== sdram_pkg.sv ====
`include "sdram_macros.svh"

package sdram_pkg;

    // Command encoding is {cs_n, ras_n, cas_n, we_n}
    typedef enum logic [3:0] {
        CMD_LOAD_MODE = 4'b0000,
        CMD_REFRESH   = 4'b0001,
        CMD_PRECHARGE = 4'b0010,
        CMD_ACTIVE    = 4'b0011,
        CMD_WRITE     = 4'b0100,
        CMD_READ      = 4'b0101,
        CMD_NOP       = 4'b0111,
        CMD_INHIBIT   = 4'b1111
    } sdram_cmd_e;

    // Everything the controller puts on the device pins except dq
    typedef struct packed {
        logic        cs_n;
        logic        ras_n;
        logic        cas_n;
        logic        we_n;
        logic [12:0] a;
        logic [1:0]  ba;
        logic [1:0]  dqm;
    } sdram_pins_t;

    // cas_latency is 2 or 3, bl_code 0..3 gives 1, 2, 4 or 8 beats
    typedef struct packed {
        logic [2:0] cas_latency;
        logic [2:0] bl_code;
    } mode_cfg_t;

    // One host access, be is active high per byte
    typedef struct packed {
        logic                       write;
        logic [1:0]                 bank;
        logic [`SDRAM_ROW_BITS-1:0] row;
        logic [`SDRAM_COL_BITS-1:0] col;
        logic [1:0]                 be;
    } host_req_t;

    typedef enum logic [3:0] {
        INIT, IDLE, LOAD, ACT, WAIT_RCD, RD, RD_WAIT, WR, PRE
    } ctrl_state_e;

endpackage

// ==== sdram_subsys_top.sv ====
module sdram_subsys_top (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  cfg_wr,
    input  sdram_pkg::mode_cfg_t  cfg_in,
    input  logic                  req,
    input  sdram_pkg::host_req_t  req_info,
    input  logic [15:0]           wdata,
    output logic                  ready,
    output logic                  wdata_take,
    output logic [15:0]           rdata,
    output logic                  rdata_valid,
    output logic                  done
);
    import sdram_pkg::*;

    mode_cfg_t   cfg;
    logic        mode_pending;
    logic        mode_loaded;
    sdram_pins_t pins;
    logic        cke;
    // Shared bidirectional data bus
    wire  [15:0] dq;

    // No power-down support
    assign cke = 1'b1;

    sdram_mode_regs u_mode (
        .clk          (clk),
        .rst_n        (rst_n),
        .cfg_wr       (cfg_wr),
        .cfg_in       (cfg_in),
        .mode_loaded  (mode_loaded),
        .cfg          (cfg),
        .mode_pending (mode_pending)
    );

    sdram_ctrl u_ctrl (
        .clk          (clk),
        .rst_n        (rst_n),
        .req          (req),
        .req_info     (req_info),
        .wdata        (wdata),
        .cfg          (cfg),
        .mode_pending (mode_pending),
        .ready        (ready),
        .wdata_take   (wdata_take),
        .rdata_valid  (rdata_valid),
        .done         (done),
        .mode_loaded  (mode_loaded),
        .rdata        (rdata),
        .pins         (pins),
        .dq           (dq)
    );

    // Struct split onto the device pins
    sdram u_sdram (
        .clk (clk),
        .cke (cke),
        .cs  (pins.cs_n),
        .ras (pins.ras_n),
        .cas (pins.cas_n),
        .we  (pins.we_n),
        .a   (pins.a),
        .ba  (pins.ba),
        .dqm (pins.dqm),
        .dq  (dq)
    );

endmodule

// ==== sdram_sva.sv ====
`include "sdram_macros.svh"

module sdram_sva (
    input logic                   clk,
    input logic                   rst_n,
    input sdram_pkg::ctrl_state_e state,
    input logic [2:0]             rd_pipe,
    input sdram_pkg::sdram_pins_t pins,
    input logic                   ready,
    input logic                   req,
    input logic                   done
);
    import sdram_pkg::*;

    sdram_cmd_e cmd;
    logic       busy;

    assign cmd = sdram_cmd_e'({pins.cs_n, pins.ras_n, pins.cas_n, pins.we_n});

    // Set on acceptance, cleared after the closing done
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy <= 1'b0;
        end else if (ready && req) begin
            busy <= 1'b1;
        end else if (done) begin
            busy <= 1'b0;
        end
    end

    // Read beats in flight hold the controller in the read states and off dq
    assert property (@(posedge clk) disable iff (!rst_n)
        (rd_pipe != 3'b000) |-> (state inside {RD, RD_WAIT, PRE}))
        else $error("controller left the read states with read beats in flight");

    assert property (@(posedge clk) disable iff (!rst_n)
        (cmd == CMD_READ || cmd == CMD_WRITE) |-> ($past(cmd, `SDRAM_TRCD) == CMD_ACTIVE))
        else $error("READ or WRITE without ACTIVE tRCD cycles earlier");

    assert property (@(posedge clk) disable iff (!rst_n)
        (busy && !done) |-> !ready)
        else $error("ready high while an access is running");

endmodule

bind sdram_ctrl sdram_sva u_sva (
    .clk     (clk),
    .rst_n   (rst_n),
    .state   (state),
    .rd_pipe (rd_pipe),
    .pins    (pins),
    .ready   (ready),
    .req     (req),
    .done    (done)
);

// ==== tb_sdram.sv ====
`include "sdram_macros.svh"

module tb_sdram;
    import sdram_pkg::*;

    localparam int ROW_W = `SDRAM_ROW_BITS;
    localparam int COL_W = `SDRAM_COL_BITS;
    // About 70 accesses and mode loads, each well under 40 clocks
    localparam int N_ACCESS   = 70;
    localparam int ACCESS_CYC = 40;
    localparam int WATCHDOG_T = (N_ACCESS * ACCESS_CYC + 100) * 100;

    logic        clk;
    logic        rst_n;
    logic        cfg_wr;
    mode_cfg_t   cfg_in;
    logic        req;
    host_req_t   req_info;
    logic [15:0] wdata;
    logic        ready;
    logic        wdata_take;
    logic [15:0] rdata;
    logic        rdata_valid;
    logic        done;

    // Reference image with per-byte written flags
    logic [15:0] ref_mem [4][1 << ROW_W][1 << COL_W];
    logic [1:0]  ref_vld [4][1 << ROW_W][1 << COL_W];
    logic [15:0] wbuf [8];
    int          cur_bl;
    int          errors;
    int          checks;
    logic [31:0] lcg_state;

    sdram_subsys_top UUT (
        .clk         (clk),
        .rst_n       (rst_n),
        .cfg_wr      (cfg_wr),
        .cfg_in      (cfg_in),
        .req         (req),
        .req_info    (req_info),
        .wdata       (wdata),
        .ready       (ready),
        .wdata_take  (wdata_take),
        .rdata       (rdata),
        .rdata_valid (rdata_valid),
        .done        (done)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        #(WATCHDOG_T);
        $display("Timeout: the tests did not finish in the expected time");
        $display("=== FAIL ===");
        $finish;
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // Only bytes written so far are compared
    task automatic check_word(input string name, input logic [15:0] exp,
                              input logic [1:0] vld, input logic [15:0] act);
        logic [15:0] mask;
        mask = {{8{vld[1]}}, {8{vld[0]}}};
        checks++;
        if ((act & mask) !== (exp & mask)) begin
            errors++;
            $display("FAILED %s expected %h actual %h", name, exp & mask, act & mask);
        end
    endtask

    task automatic ref_write(input logic [1:0] bank, input logic [ROW_W-1:0] row,
                             input logic [COL_W-1:0] col, input logic [1:0] be,
                             input logic [15:0] d);
        if (be[0]) begin
            ref_mem[bank][row][col][7:0] = d[7:0];
        end
        if (be[1]) begin
            ref_mem[bank][row][col][15:8] = d[15:8];
        end
        ref_vld[bank][row][col] = ref_vld[bank][row][col] | be;
    endtask

    task automatic wait_ready();
        @(negedge clk);
        while (!ready) begin
            @(negedge clk);
        end
    endtask

    // One burst, write beats from wbuf, read beats checked in column order
    task automatic run_access(input string name, input logic write, input logic [1:0] bank,
                              input logic [ROW_W-1:0] row, input logic [COL_W-1:0] col,
                              input logic [1:0] be);
        int               tcnt;
        int               vcnt;
        logic             take;
        logic             fin;
        logic [COL_W-1:0] c;
        tcnt = 0;
        vcnt = 0;
        fin  = 1'b0;
        wait_ready();
        @(posedge clk);
        req      <= 1'b1;
        req_info <= {write, bank, row, col, be};
        // Beat 0 sits on wdata before the first take
        wdata    <= wbuf[0];
        @(posedge clk);
        req <= 1'b0;
        while (!fin) begin
            @(negedge clk);
            take = wdata_take;
            if (rdata_valid) begin
                c = col + COL_W'(vcnt);
                if (write || vcnt >= cur_bl) begin
                    errors++;
                    $display("%s: read beat seen where none was due", name);
                end else begin
                    check_word(name, ref_mem[bank][row][c], ref_vld[bank][row][c], rdata);
                end
                vcnt++;
            end
            fin = done;
            @(posedge clk);
            if (take) begin
                if (tcnt < cur_bl) begin
                    ref_write(bank, row, col + COL_W'(tcnt), be, wbuf[tcnt]);
                end
                tcnt++;
                if (tcnt < cur_bl) begin
                    wdata <= wbuf[tcnt];
                end
            end
        end
        checks++;
        if ((write ? tcnt : vcnt) != cur_bl) begin
            errors++;
            $display("FAILED %s beat count expected %0d actual %0d", name, cur_bl,
                     write ? tcnt : vcnt);
        end
    endtask

    // Mode write, then expect one LOAD_MODE and one done
    task automatic set_mode(input string name, input logic [2:0] cl, input logic [2:0] code);
        int ndone;
        int cyc;
        ndone = 0;
        cyc   = 0;
        wait_ready();
        @(posedge clk);
        cfg_wr <= 1'b1;
        cfg_in <= {cl, code};
        @(posedge clk);
        cfg_wr <= 1'b0;
        do begin
            @(negedge clk);
            cyc++;
            if (done) begin
                ndone++;
            end
        end while (!ready);
        cur_bl = 1 << code;
        checks++;
        if (ndone != 1) begin
            errors++;
            $display("FAILED %s done count expected 1 actual %0d", name, ndone);
        end
        if (cyc > 3) begin
            errors++;
            $display("%s: mode load took %0d cycles to complete", name, cyc);
        end
    endtask

    task automatic burst_default();
        for (int i = 0; i < 4; i++) begin
            wbuf[i] = 16'(lcg_next() >> 16);
        end
        run_access("burst_default_wr", 1'b1, 2'd0, 4'd2, 5'd4, 2'b11);
        run_access("burst_default_rd", 1'b0, 2'd0, 4'd2, 5'd4, 2'b11);
    endtask

    task automatic byte_masks();
        for (int i = 0; i < 4; i++) begin
            wbuf[i] = 16'hA5C3 ^ 16'(i * 16'h1111);
        end
        run_access("byte_masks_fill", 1'b1, 2'd2, 4'd7, 5'd8, 2'b11);
        for (int i = 0; i < 4; i++) begin
            wbuf[i] = 16'h5A00 + 16'(i);
        end
        // Low byte only
        run_access("byte_masks_lo", 1'b1, 2'd2, 4'd7, 5'd8, 2'b01);
        for (int i = 0; i < 4; i++) begin
            wbuf[i] = 16'h00F0 + 16'(i << 8);
        end
        // High byte only
        run_access("byte_masks_hi", 1'b1, 2'd2, 4'd7, 5'd8, 2'b10);
        run_access("byte_masks_rd", 1'b0, 2'd2, 4'd7, 5'd8, 2'b11);
    endtask

    task automatic mode_change();
        set_mode("mode_bl8_cl3", 3'd3, 3'd3);
        for (int i = 0; i < 8; i++) begin
            wbuf[i] = 16'(lcg_next() >> 16);
        end
        run_access("mode_bl8_wr", 1'b1, 2'd1, 4'd3, 5'd16, 2'b11);
        run_access("mode_bl8_rd", 1'b0, 2'd1, 4'd3, 5'd16, 2'b11);
        set_mode("mode_bl1_cl2", 3'd2, 3'd0);
        wbuf[0] = 16'hBEEF;
        run_access("mode_bl1_wr", 1'b1, 2'd1, 4'd3, 5'd17, 2'b11);
        run_access("mode_bl1_rd", 1'b0, 2'd1, 4'd3, 5'd17, 2'b11);
        run_access("mode_bl1_rd_old", 1'b0, 2'd1, 4'd3, 5'd16, 2'b11);
    endtask

    // Same column across banks and rows
    task automatic bank_isolation();
        for (int i = 0; i < 6; i++) begin
            wbuf[0] = 16'hC000 + 16'(i);
            run_access("isolation_wr", 1'b1, 2'(i % 4), ROW_W'(i * 5), 5'd5, 2'b11);
        end
        for (int i = 0; i < 6; i++) begin
            run_access("isolation_rd", 1'b0, 2'(i % 4), ROW_W'(i * 5), 5'd5, 2'b11);
        end
    endtask

    task automatic random_traffic();
        logic [31:0] r;
        set_mode("mode_bl2_cl2", 3'd2, 3'd1);
        for (int n = 0; n < 40; n++) begin
            r = lcg_next();
            wbuf[0] = 16'(lcg_next() >> 16);
            wbuf[1] = 16'(lcg_next() >> 16);
            // Small address window so reads hit earlier writes
            run_access("random", r[31], r[30:29], ROW_W'(r[28]),
                       COL_W'({r[24:23], 1'b0}), r[20:19]);
        end
    endtask

    initial begin
        rst_n    <= 1'b0;
        cfg_wr   <= 1'b0;
        cfg_in   <= '0;
        req      <= 1'b0;
        req_info <= '0;
        wdata    <= '0;
        lcg_state = 32'h6958_b7da;
        errors    = 0;
        checks    = 0;
        cur_bl    = 1 << `SDRAM_DEF_BL_CODE;
        foreach (ref_vld[b, r, c]) begin
            ref_vld[b][r][c] = 2'b00;
        end
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        burst_default();
        byte_masks();
        mode_change();
        bank_isolation();
        random_traffic();
        $display("Checks: %0d  Errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule
